// ==== src/starfield_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// starfield package
// frame geometry, star ROM sizes and the packed types shared by the
// two-layer star-field background generator
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package starfield_pkg;

    // frame geometry in pixels and lines
    localparam int h_total       = 128;
    localparam int v_total       = 40;
    localparam int v_blank_start = 32;

    // star ROM shape
    localparam int rom_aw    = 13;
    localparam int rom_dw    = 32;
    localparam int rom_words = 1 << rom_aw;

    // color code that lets the layer below show through
    localparam logic [3:0] color_transparent = 4'hf;

    // read request from one layer toward the arbiter
    typedef struct packed {
        logic [rom_aw-1:0] addr;
        logic              req;
    } star_req_t;

    // 7-bit layer pixel, palette on top
    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] color;
    } star_pixel_t;

    // merged pixel tagged with its screen position
    typedef struct packed {
        star_pixel_t pix;
        logic        layer;
        logic [8:0]  h;
        logic [8:0]  v;
        logic        vb;
    } video_out_t;

    // host load of one ROM word
    typedef struct packed {
        logic [rom_aw-1:0] addr;
        logic [rom_dw-1:0] data;
    } rom_wr_t;

endpackage

`default_nettype wire

// ==== src/video_timing.sv ====
////////////////////////////////////////////////////////////////////////////
// video timing generator
// divide-by-two pixel strobe, horizontal and vertical dump counters and
// vertical blank, all held at the frame origin while video is disabled
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    output logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       vb
);
    import starfield_pkg::*;

    logic h_last;
    logic v_last;

    // wrap points of the two counters
    assign h_last = hdump == 9'(h_total - 1);
    assign v_last = vdump == 9'(v_total - 1);

    // pixel strobe on every second clock
    // first strobe lands one clock after enable rises
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
        end else if (!enable) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // raster counters
    // parked at 0,0 so a new enable starts a clean frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (!enable) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= '0;
                // line done, step the vertical count
                if (v_last) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 9'd1;
                end
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    // bottom lines of the frame are blank
    assign vb = vdump >= 9'(v_blank_start);

endmodule

`default_nettype wire

// ==== src/star_layer.sv ====
////////////////////////////////////////////////////////////////////////////
// star layer
// one scrolling star field: forms the star ROM address, picks its byte
// lane from the returned word, runs the two blink counters and draws one
// pixel per pixel strobe
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module star_layer #(
    parameter int unsigned field = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     vb,
    input  logic                     flip,
    input  logic [8:0]               hdump,
    input  logic [8:0]               vdump,
    input  logic [8:0]               hpos,
    input  logic [8:0]               vpos,
    output starfield_pkg::star_req_t req,
    input  logic [31:0]              rom_data,
    input  logic                     rom_ok,
    output starfield_pkg::star_pixel_t pxl
);
    import starfield_pkg::*;

    logic [8:0] heff_now;
    logic [8:0] veff_now;
    logic [8:0] heff_r;
    logic [8:0] veff_r;
    logic [7:0] lane;
    logic [2:0] pal_q;
    logic [4:0] pos_q;
    logic [2:0] pal_cur;
    logic [4:0] pos_cur;
    logic [4:0] blank_code;
    logic [3:0] cnt15;
    logic [3:0] cnt16;

    // scrolled position of the pixel being fetched
    assign heff_now = hpos + hdump;
    assign veff_now = (vpos + vdump) ^ {9{flip}};

    // position of the pixel in flight, one strobe behind the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            heff_r <= '0;
            veff_r <= '0;
        end else if (pxl_cen) begin
            heff_r <= heff_now;
            veff_r <= veff_now;
        end
    end

    // slot 0 sits in the strobe clock, slot 1 in the clock after it
    // so the second slot reads the held position of the same pixel
    assign req.addr = pxl_cen ? {heff_now[8:5], veff_now} : {heff_r[8:5], veff_r};
    // a layer fetches on every pixel
    assign req.req  = 1'b1;

    // this layer's byte of the star word
    assign lane = rom_data[field*8 +: 8];

    // star word latch, no star until the first fetch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_q <= '0;
            pos_q <= 5'h0f;
        end else if (rom_ok) begin
            pal_q <= lane[7:5];
            pos_q <= lane[4:0] ^ {5{flip}};
        end
    end

    // slot 1 data arrives with the strobe itself, take it straight
    assign pal_cur = rom_ok ? lane[7:5] : pal_q;
    assign pos_cur = rom_ok ? lane[4:0] ^ {5{flip}} : pos_q;

    assign blank_code = 5'h0f ^ {5{flip}};

    // blink counters, stepped once per 32 pixels, cleared in blank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt15 <= '0;
            cnt16 <= '0;
        end else if (pxl_cen) begin
            if (vb) begin
                cnt15 <= '0;
                cnt16 <= '0;
            end else if (&hdump[4:0]) begin
                // mod 15 never reaches the transparent code
                cnt15 <= (cnt15 == 4'd14) ? 4'd0 : cnt15 + 4'd1;
                cnt16 <= cnt16 + 4'd1;
            end
        end
    end

    // star rule
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl.pal   <= '0;
            pxl.color <= color_transparent;
        end else if (pxl_cen) begin
            pxl.pal <= pal_cur;
            if (pos_cur == heff_r[4:0] && pos_cur != blank_code) begin
                pxl.color <= pal_cur[2] ? cnt15 : cnt16;
            end else begin
                pxl.color <= color_transparent;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/star_rom.sv ====
////////////////////////////////////////////////////////////////////////////
// star ROM
// 8192 x 32 star table with registered read and a host load port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module star_rom (
    input  logic                            clk,
    input  logic [starfield_pkg::rom_aw-1:0] addr,
    input  logic                            we,
    input  logic [starfield_pkg::rom_dw-1:0] wdata,
    output logic [starfield_pkg::rom_dw-1:0] rdata
);
    import starfield_pkg::*;

    logic [rom_dw-1:0] mem [rom_words];

    // host load, one word per strobe
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // one clock of read latency
    // a read during a write returns the old word, nobody takes it
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== src/star_rom_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// star ROM arbiter
// fixed two-slot share of the ROM read port between the star layers,
// with host writes taking the port over in any clock
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module star_rom_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  starfield_pkg::star_req_t   req0,
    input  starfield_pkg::star_req_t   req1,
    input  logic                       wr,
    input  starfield_pkg::rom_wr_t     wr_data,
    output logic [12:0]                rom_addr,
    output logic                       rom_we,
    output logic [31:0]                rom_wdata,
    output logic                       ok0,
    output logic                       ok1
);

    logic slot;
    logic grant0;
    logic grant1;

    // slot 1 is the clock right after the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot <= 1'b0;
        end else begin
            slot <= pxl_cen;
        end
    end

    // a write steals the slot, the layer keeps its old word
    assign grant0 = pxl_cen & req0.req & ~wr;
    assign grant1 = slot & req1.req & ~wr;

    // port mux
    always_comb begin
        if (wr) begin
            rom_addr = wr_data.addr;
        end else if (slot) begin
            rom_addr = req1.addr;
        end else begin
            rom_addr = req0.addr;
        end
    end

    assign rom_we    = wr;
    assign rom_wdata = wr_data.data;

    // data valid one clock after the granted slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ok0 <= 1'b0;
            ok1 <= 1'b0;
        end else begin
            ok0 <= grant0;
            ok1 <= grant1;
        end
    end

endmodule

`default_nettype wire

// ==== src/star_mixer.sv ====
////////////////////////////////////////////////////////////////////////////
// star mixer
// merges the two layer pixels with layer 0 on top and tags the result
// with the screen position it belongs to
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module star_mixer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  starfield_pkg::star_pixel_t pxl0,
    input  starfield_pkg::star_pixel_t pxl1,
    input  logic [8:0]                 hdump,
    input  logic [8:0]                 vdump,
    input  logic                       vb,
    output starfield_pkg::video_out_t  out,
    output logic                       out_valid
);
    import starfield_pkg::*;

    logic [8:0] h_d1;
    logic [8:0] h_d2;
    logic [8:0] v_d1;
    logic [8:0] v_d2;
    logic       vb_d1;
    logic       vb_d2;
    logic       fill_d1;
    logic       fill_d2;
    logic       top_hit;

    // position pipe, two strobes to meet the layer pixels
    // fill bits mark stages that hold a real pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_d1    <= '0;
            h_d2    <= '0;
            v_d1    <= '0;
            v_d2    <= '0;
            vb_d1   <= 1'b0;
            vb_d2   <= 1'b0;
            fill_d1 <= 1'b0;
            fill_d2 <= 1'b0;
        end else if (pxl_cen) begin
            h_d1    <= hdump;
            h_d2    <= h_d1;
            v_d1    <= vdump;
            v_d2    <= v_d1;
            vb_d1   <= vb;
            vb_d2   <= vb_d1;
            fill_d1 <= 1'b1;
            fill_d2 <= fill_d1;
        end
    end

    // layer 0 is opaque unless transparent
    assign top_hit = pxl0.color != color_transparent;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.pix   <= '{pal: 3'd0, color: color_transparent};
            out.layer <= 1'b0;
            out.h     <= '0;
            out.v     <= '0;
            out.vb    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // one clock strobe per pixel
            out_valid <= pxl_cen & fill_d2;
            if (pxl_cen) begin
                out.pix   <= top_hit ? pxl0 : pxl1;
                out.layer <= ~top_hit;
                out.h     <= h_d2;
                out.v     <= v_d2;
                out.vb    <= vb_d2;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/starfield_top.sv ====
////////////////////////////////////////////////////////////////////////////
// star-field background top
// video timing, two star layers sharing one star ROM through a slot
// arbiter, and the layer mixer that produces the tagged output pixel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module starfield_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  logic                      flip,
    input  logic [8:0]                hpos0,
    input  logic [8:0]                vpos0,
    input  logic [8:0]                hpos1,
    input  logic [8:0]                vpos1,
    input  logic                      rom_wr,
    input  starfield_pkg::rom_wr_t    rom_wr_data,
    output starfield_pkg::video_out_t out,
    output logic                      out_valid
);
    import starfield_pkg::*;

    logic              pxl_cen;
    logic [8:0]        hdump;
    logic [8:0]        vdump;
    logic              vb;
    star_req_t         req0;
    star_req_t         req1;
    logic              ok0;
    logic              ok1;
    star_pixel_t       pxl0;
    star_pixel_t       pxl1;
    logic [rom_aw-1:0] rom_addr;
    logic              rom_we;
    logic [rom_dw-1:0] rom_wdata;
    logic [rom_dw-1:0] rom_data;

    video_timing video_timing_i (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .vb      (vb)
    );

    // front layer, byte lane 0
    star_layer #(.field(0)) star_layer0_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .vb       (vb),
        .flip     (flip),
        .hdump    (hdump),
        .vdump    (vdump),
        .hpos     (hpos0),
        .vpos     (vpos0),
        .req      (req0),
        .rom_data (rom_data),
        .rom_ok   (ok0),
        .pxl      (pxl0)
    );

    // back layer, byte lane 1
    star_layer #(.field(1)) star_layer1_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .vb       (vb),
        .flip     (flip),
        .hdump    (hdump),
        .vdump    (vdump),
        .hpos     (hpos1),
        .vpos     (vpos1),
        .req      (req1),
        .rom_data (rom_data),
        .rom_ok   (ok1),
        .pxl      (pxl1)
    );

    star_rom_arbiter star_rom_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .req0      (req0),
        .req1      (req1),
        .wr        (rom_wr),
        .wr_data   (rom_wr_data),
        .rom_addr  (rom_addr),
        .rom_we    (rom_we),
        .rom_wdata (rom_wdata),
        .ok0       (ok0),
        .ok1       (ok1)
    );

    star_rom star_rom_i (
        .clk   (clk),
        .addr  (rom_addr),
        .we    (rom_we),
        .wdata (rom_wdata),
        .rdata (rom_data)
    );

    star_mixer star_mixer_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pxl0      (pxl0),
        .pxl1      (pxl1),
        .hdump     (hdump),
        .vdump     (vdump),
        .vb        (vb),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== sim/starfield_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// star-field testbench
// loads the star ROM through the host port, runs the video and compares
// every tagged output pixel with a shadow ROM and a model of the star rule
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module starfield_tb;
    import starfield_pkg::*;

    localparam int clk_ns    = 8;
    localparam int frame_ns  = h_total * v_total * 2 * clk_ns;
    localparam int num_tests = 6;

    logic       clk;
    logic       rst;
    logic       enable;
    logic       flip;
    logic [8:0] hpos0;
    logic [8:0] vpos0;
    logic [8:0] hpos1;
    logic [8:0] vpos1;
    logic       rom_wr;
    rom_wr_t    rom_wr_data;
    video_out_t out;
    logic       out_valid;

    // what the ROM should hold
    logic [rom_dw-1:0] shadow [rom_words];

    starfield_top starfield_top_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .flip        (flip),
        .hpos0       (hpos0),
        .vpos0       (vpos0),
        .hpos1       (hpos1),
        .vpos1       (vpos1),
        .rom_wr      (rom_wr),
        .rom_wr_data (rom_wr_data),
        .out         (out),
        .out_valid   (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    task automatic stop_failed(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_idle(input logic got_valid, input string what);
        if (got_valid !== 1'b0) begin
            stop_failed($sformatf("CHECK FAILED at %0t ns: %s, out_valid is %b",
                                  $time, what, got_valid));
        end
    endtask

    task automatic check_pixel(input video_out_t got, input video_out_t want,
                               input string what);
        if (got !== want) begin
            stop_failed($sformatf({"CHECK FAILED at %0t ns: %s at h=%0d v=%0d, ",
                                   "got %h expected %h"},
                                  $time, what, want.h, want.v, got, want));
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            stop_failed($sformatf("CHECK FAILED at %0t ns: %s, got %0d expected %0d",
                                  $time, what, got, want));
        end
    endtask

    // background word with every lane blank
    // palette bits hashed from the whole address
    function automatic logic [rom_dw-1:0] quiet_word(input logic [rom_aw-1:0] addr);
        logic [2:0]        mix;
        logic [rom_dw-1:0] word;
        mix = addr[2:0] ^ addr[5:3] ^ addr[8:6] ^ addr[11:9] ^ {2'b00, addr[12]};
        for (int k = 0; k < 4; k++) begin
            word[k*8 +: 8] = {mix ^ 3'(k), 5'h0f};
        end
        return word;
    endfunction

    // star column that avoids the blank code
    function automatic logic [4:0] star_col(input int x);
        logic [4:0] c;
        c = 5'(x);
        if (c == 5'h0f) begin
            c = 5'h10;
        end
        return c;
    endfunction

    // front layer star seen at one screen position above the blank lines
    function automatic video_out_t front_star(input logic [2:0] pal,
            input logic [3:0] color, input logic [8:0] h, input logic [8:0] v);
        video_out_t p;
        p.pix.pal   = pal;
        p.pix.color = color;
        p.layer     = 1'b0;
        p.h         = h;
        p.v         = v;
        p.vb        = 1'b0;
        return p;
    endfunction

    // star rule for one layer at screen position h, v
    function automatic star_pixel_t layer_model(input int lane_sel,
            input logic [8:0] h, input logic [8:0] v,
            input logic [8:0] hp, input logic [8:0] vp,
            input logic [3:0] c15, input logic [3:0] c16);
        logic [8:0]        heff;
        logic [8:0]        veff;
        logic [rom_dw-1:0] word;
        logic [7:0]        lane_byte;
        logic [4:0]        pos;
        star_pixel_t       p;
        heff      = hp + h;
        veff      = (vp + v) ^ {9{flip}};
        word      = shadow[{heff[8:5], veff}];
        lane_byte = word[lane_sel*8 +: 8];
        pos       = lane_byte[4:0] ^ {5{flip}};
        p.pal     = lane_byte[7:5];
        if (pos == heff[4:0] && pos != (5'h0f ^ {5{flip}})) begin
            p.color = lane_byte[7] ? c15 : c16;
        end else begin
            p.color = color_transparent;
        end
        return p;
    endfunction

    task automatic write_word(input logic [rom_aw-1:0] addr, input logic [rom_dw-1:0] data);
        @(posedge clk);
        rom_wr      <= 1'b1;
        rom_wr_data <= '{addr: addr, data: data};
        shadow[addr] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        rom_wr <= 1'b0;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst    <= 1'b1;
        enable <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic set_scroll(input logic [8:0] h0, input logic [8:0] v0,
                              input logic [8:0] h1, input logic [8:0] v1, input logic f);
        @(posedge clk);
        hpos0 <= h0;
        vpos0 <= v0;
        hpos1 <= h1;
        vpos1 <= v1;
        flip  <= f;
    endtask

    // enable video and check every output pixel of whole frames
    // lit0 and lit1 count the stars the DUT showed from each layer
    // star keeps the last lit pixel the DUT showed
    task automatic run_frames(input int frames, input string what,
                              output int lit0, output int lit1,
                              output video_out_t star);
        logic [8:0]  h;
        logic [8:0]  v;
        logic [3:0]  c15;
        logic [3:0]  c16;
        star_pixel_t p0;
        star_pixel_t p1;
        video_out_t  want;
        h    = '0;
        v    = '0;
        c15  = '0;
        c16  = '0;
        lit0 = 0;
        lit1 = 0;
        star = '0;
        @(posedge clk);
        enable <= 1'b1;
        for (int n = 0; n < frames * h_total * v_total; n++) begin
            @(negedge clk);
            while (out_valid !== 1'b1) begin
                @(negedge clk);
            end
            // blink counters include the pixel's own position
            if (v >= 9'(v_blank_start)) begin
                c15 = '0;
                c16 = '0;
            end else if (&h[4:0]) begin
                c15 = (c15 == 4'd14) ? 4'd0 : c15 + 4'd1;
                c16 = c16 + 4'd1;
            end
            p0 = layer_model(0, h, v, hpos0, vpos0, c15, c16);
            p1 = layer_model(1, h, v, hpos1, vpos1, c15, c16);
            // front layer wins unless transparent
            want.pix   = (p0.color != color_transparent) ? p0 : p1;
            want.layer = p0.color == color_transparent;
            want.h     = h;
            want.v     = v;
            want.vb    = v >= 9'(v_blank_start);
            check_pixel(out, want, what);
            if (out.pix.color != color_transparent) begin
                star = out;
                if (out.layer) begin
                    lit1++;
                end else begin
                    lit0++;
                end
            end
            // raster order of the expected stream
            if (h == 9'(h_total - 1)) begin
                h = '0;
                v = (v == 9'(v_total - 1)) ? 9'd0 : v + 9'd1;
            end else begin
                h = h + 9'd1;
            end
        end
        @(posedge clk);
        enable <= 1'b0;
    endtask

    // quiet ROM load with video off
    // no pixel may come out
    task automatic idle_after_reset();
        for (int a = 0; a < rom_words; a++) begin
            write_word(rom_aw'(a), quiet_word(rom_aw'(a)));
            @(negedge clk);
            check_idle(out_valid, "during ROM load");
        end
        end_writes();
        repeat (100) begin
            @(negedge clk);
            check_idle(out_valid, "enable low");
        end
    endtask

    // one star at column 9 of line 5
    task automatic single_star();
        logic [rom_aw-1:0] a;
        logic [rom_dw-1:0] w;
        int                lit0;
        int                lit1;
        video_out_t        star;
        a = {4'd0, 9'd5};
        w = quiet_word(a);
        w[7:0] = {3'b100, 5'd9};
        reset_dut();
        set_scroll(9'd0, 9'd0, 9'd0, 9'd0, 1'b0);
        write_word(a, w);
        end_writes();
        run_frames(1, "single star", lit0, lit1, star);
        check_count(lit0, 1, "single star, front layer stars");
        check_count(lit1, 0, "single star, back layer stars");
        // 20 blink steps before line 5 leave the mod-15 count at 5
        check_pixel(star, front_star(3'b100, 4'd5, 9'd9, 9'd5), "single star place");
        write_word(a, quiet_word(a));
        end_writes();
    endtask

    // scroll 37,11 puts the star word at {1, 19} on screen at 20,8
    task automatic scrolled_star();
        logic [rom_aw-1:0] a;
        logic [rom_dw-1:0] w;
        int                lit0;
        int                lit1;
        video_out_t        star;
        a = {4'd1, 9'd19};
        w = quiet_word(a);
        w[7:0] = {3'b101, 5'd25};
        reset_dut();
        set_scroll(9'd37, 9'd11, 9'd5, 9'd3, 1'b0);
        write_word(a, w);
        end_writes();
        run_frames(1, "scrolled star", lit0, lit1, star);
        check_count(lit0, 1, "scrolled star, front layer stars");
        check_count(lit1, 0, "scrolled star, back layer stars");
        // 32 blink steps before line 8 leave the mod-15 count at 2
        check_pixel(star, front_star(3'b101, 4'd2, 9'd20, 9'd8), "scrolled star place");
        write_word(a, quiet_word(a));
        end_writes();
    endtask

    // flipped line 6 reads line 0x1f9
    // back lane holds the code that flip turns into the blank code
    task automatic flipped_star();
        logic [rom_aw-1:0] a;
        logic [rom_dw-1:0] w;
        int                lit0;
        int                lit1;
        video_out_t        star;
        a = {4'd0, 9'h1f9};
        w = quiet_word(a);
        w[7:0]  = {3'b110, 5'd19};
        w[15:8] = {3'b111, 5'h0f};
        reset_dut();
        set_scroll(9'd0, 9'd0, 9'd0, 9'd0, 1'b1);
        write_word(a, w);
        end_writes();
        run_frames(1, "flipped star", lit0, lit1, star);
        check_count(lit0, 1, "flipped star, front layer stars");
        check_count(lit1, 0, "flipped star, back layer stars");
        // column 19 flips to 12, 24 blink steps leave the mod-15 count at 9
        check_pixel(star, front_star(3'b110, 4'd9, 9'd12, 9'd6), "flipped star place");
        write_word(a, quiet_word(a));
        end_writes();
    endtask

    // stars on every line
    // even column groups overlap both layers
    task automatic priority_and_blink();
        logic [rom_aw-1:0] a;
        logic [rom_dw-1:0] w;
        logic [4:0]        p;
        int                lit0;
        int                lit1;
        video_out_t        star;
        reset_dut();
        set_scroll(9'd0, 9'd0, 9'd0, 9'd0, 1'b0);
        for (int v = 0; v < v_total; v++) begin
            for (int g = 0; g < 4; g++) begin
                a = {4'(g), 9'(v)};
                p = star_col(v * 7 + g * 3);
                w = quiet_word(a);
                w[7:0] = {(v % 2 == 1) ? 3'b100 : 3'b011, p};
                if (g % 2 == 0) begin
                    w[15:8] = {3'b010, p};
                end else begin
                    w[15:8] = {3'b101, star_col(v * 7 + g * 3 + 9)};
                end
                write_word(a, w);
            end
        end
        end_writes();
        run_frames(2, "priority and blink", lit0, lit1, star);
        if (lit0 == 0 || lit1 == 0) begin
            stop_failed("priority test showed no stars from one of the layers");
        end
    endtask

    // random ROM and random scroll on both layers
    task automatic random_rom();
        int         lit0;
        int         lit1;
        video_out_t star;
        reset_dut();
        for (int a = 0; a < rom_words; a++) begin
            write_word(rom_aw'(a), $urandom);
        end
        end_writes();
        set_scroll(9'($urandom), 9'($urandom), 9'($urandom), 9'($urandom), 1'b0);
        run_frames(2, "random ROM", lit0, lit1, star);
    endtask

    initial begin
        void'($urandom(14299));
        rst         = 1'b1;
        enable      = 1'b0;
        flip        = 1'b0;
        hpos0       = '0;
        vpos0       = '0;
        hpos1       = '0;
        vpos1       = '0;
        rom_wr      = 1'b0;
        rom_wr_data = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        single_star();
        scrolled_star();
        flipped_star();
        priority_and_blink();
        random_rom();
        $display("Everything OK");
        $finish;
    end

    // six frames of budget per test
    initial begin
        #(num_tests * 6 * frame_ns);
        stop_failed("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// ==== starfield_top.f ====
src/starfield_pkg.sv
src/video_timing.sv
src/star_layer.sv
src/star_rom.sv
src/star_rom_arbiter.sv
src/star_mixer.sv
src/starfield_top.sv
sim/starfield_tb.sv

// ==== Bender.yml ====
package:
  name: starfield

sources:
  - src/starfield_pkg.sv
  - src/video_timing.sv
  - src/star_layer.sv
  - src/star_rom.sv
  - src/star_rom_arbiter.sv
  - src/star_mixer.sv
  - src/starfield_top.sv
  - target: test
    files:
      - sim/starfield_tb.sv
